//--- hdl/ex_alu.sv
// Integer ALU
// Add, subtract, logic, shifts, set-less-than and branch compares

`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e       operator_i,
  input  logic [`EX_XLEN-1:0]   operand_a_i,
  input  logic [`EX_XLEN-1:0]   operand_b_i,
  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  // Reverses the bit order of a word
  function automatic logic [`EX_XLEN-1:0] bit_rev(input logic [`EX_XLEN-1:0] v);
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < `EX_XLEN; i++) begin
      r[i] = v[`EX_XLEN-1-i];
    end
    return r;
  endfunction

  ////////////////////
  // Adder
  ////////////////////

  logic                do_sub;
  logic [`EX_XLEN-1:0] b_mux;
  logic [`EX_XLEN:0]   sum_ext;
  logic [`EX_XLEN-1:0] sum;
  logic                carry;
  logic                is_eq;
  logic                lt_u;
  logic                lt_s;

  // Everything except ADD goes through the subtract path
  assign do_sub  = (operator_i != ex_pkg::ADD);
  assign b_mux   = do_sub ? ~operand_b_i : operand_b_i;
  assign sum_ext = {1'b0, operand_a_i} + {1'b0, b_mux} + {{`EX_XLEN{1'b0}}, do_sub};
  assign sum     = sum_ext[`EX_XLEN-1:0];
  assign carry   = sum_ext[`EX_XLEN];

  // Compare flags from a - b
  assign is_eq = (sum == '0);
  // No carry out means a borrow, so a < b unsigned
  assign lt_u  = ~carry;
  // Signs differ: a negative wins; else the difference sign decides
  assign lt_s  = (operand_a_i[`EX_XLEN-1] != operand_b_i[`EX_XLEN-1]) ?
                 operand_a_i[`EX_XLEN-1] : sum[`EX_XLEN-1];

  ////////////////////
  // Shifter
  ////////////////////

  logic                     shift_left;
  logic                     shift_arith;
  logic [`EX_XLEN-1:0]      shift_in;
  logic signed [`EX_XLEN:0] shift_ext;
  logic [`EX_XLEN:0]        shift_out;
  logic [`EX_XLEN-1:0]      shift_r;

  assign shift_left  = (operator_i == ex_pkg::SLL);
  assign shift_arith = (operator_i == ex_pkg::SRA);
  // Left shift is a right shift of the reversed operand
  assign shift_in    = shift_left ? bit_rev(operand_a_i) : operand_a_i;
  assign shift_ext   = {shift_arith & shift_in[`EX_XLEN-1], shift_in};
  assign shift_out   = shift_ext >>> operand_b_i[SHAMT_W-1:0];
  assign shift_r     = shift_out[`EX_XLEN-1:0];

  ////////////////////
  // Compare and result
  ////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::EQ:                cmp_result_o = is_eq;
      ex_pkg::NE:                cmp_result_o = ~is_eq;
      ex_pkg::LT, ex_pkg::SLT:   cmp_result_o = lt_s;
      ex_pkg::GE:                cmp_result_o = ~lt_s;
      ex_pkg::LTU, ex_pkg::SLTU: cmp_result_o = lt_u;
      ex_pkg::GEU:               cmp_result_o = ~lt_u;
      default:                   cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ex_pkg::ADD, ex_pkg::SUB: result_o = sum;
      ex_pkg::AND:              result_o = operand_a_i & operand_b_i;
      ex_pkg::OR:               result_o = operand_a_i | operand_b_i;
      ex_pkg::XOR:              result_o = operand_a_i ^ operand_b_i;
      // Undo the operand reversal
      ex_pkg::SLL:              result_o = bit_rev(shift_r);
      ex_pkg::SRL, ex_pkg::SRA: result_o = shift_r;
      // Compares give 0 or 1
      ex_pkg::SLT, ex_pkg::SLTU, ex_pkg::EQ, ex_pkg::NE,
      ex_pkg::LT, ex_pkg::GE, ex_pkg::LTU, ex_pkg::GEU:
        result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
      default:                  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/ex_consts.svh
// Execute stage constants
// Data path, register address and opcode widths

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Integer data path width
`define EX_XLEN 32

// Register file address width
// Top bit selects the FP bank and passes through untouched
`define EX_RADDR_W 6

// ALU opcode width
`define EX_ALU_OP_W 5

// Multiplier opcode width
`define EX_MUL_OP_W 2

`endif

//--- hdl/ex_mult.sv
// Integer multiplier
// MUL in one cycle, MULH/MULHSU/MULHU over two cycles

`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  ex_pkg::mul_op_e     operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_DONE = 1'b1;

  logic                           a_signed;
  logic                           b_signed;
  logic signed [`EX_XLEN:0]       a_ext;
  logic signed [`EX_XLEN:0]       b_ext;
  logic signed [2*`EX_XLEN+1:0]   product;
  logic                           is_high;
  logic                           start_high;
  logic                           state_q;
  logic                           state_d;
  logic [`EX_XLEN-1:0]            high_q;

  ////////////////////
  // Product
  ////////////////////

  // MULH: both signed, MULHSU: only a signed, MULHU: none
  assign a_signed = (operator_i == ex_pkg::MULH) | (operator_i == ex_pkg::MULHSU);
  assign b_signed = (operator_i == ex_pkg::MULH);

  // One extra bit makes every mode a signed multiply
  assign a_ext   = {a_signed & op_a_i[`EX_XLEN-1], op_a_i};
  assign b_ext   = {b_signed & op_b_i[`EX_XLEN-1], op_b_i};
  assign product = a_ext * b_ext;

  assign is_high    = (operator_i != ex_pkg::MUL);
  // High request seen while idle
  assign start_high = (state_q == ST_IDLE) & enable_i & is_high;

  ////////////////////
  // High word FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_high) begin
          state_d = ST_DONE;
        end
      end
      // Hold the result until the stage moves on
      default: begin
        if (ex_ready_i) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper word captured in the first cycle
  always_ff @(posedge clk) begin
    if (start_high) begin
      high_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  // Outputs
  assign ready_o      = ~start_high;
  assign multicycle_o = (state_q == ST_DONE);
  assign result_o     = (state_q == ST_DONE) ? high_q : product[`EX_XLEN-1:0];

endmodule

`default_nettype wire

//--- hdl/ex_pkg.sv
// Execute stage package
// ALU and multiplier opcode encodings

`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

  // ALU operations
  // Compare ops sit in the upper codes
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD  = 5'h00,
    SUB  = 5'h01,
    AND  = 5'h02,
    OR   = 5'h03,
    XOR  = 5'h04,
    SLL  = 5'h05,
    SRL  = 5'h06,
    SRA  = 5'h07,
    SLT  = 5'h08,
    SLTU = 5'h09,
    // Branch compares
    EQ   = 5'h0c,
    NE   = 5'h0d,
    LT   = 5'h10,
    GE   = 5'h11,
    LTU  = 5'h12,
    GEU  = 5'h13
  } alu_op_e;

  // Multiplier operations
  // Only MUL returns the low word
  typedef enum logic [`EX_MUL_OP_W-1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_e;

endpackage

`default_nettype wire

//--- hdl/ex_stage.sv
// Execute stage top
// ALU, multiplier and write-back control with branch outputs

`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // ALU from ID
  input  ex_pkg::alu_op_e        alu_operator_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_c_i,
  input  logic                   alu_en_i,
  // Multiplier from ID
  input  ex_pkg::mul_op_e        mult_operator_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_b_i,
  input  logic                   mult_en_i,
  output logic                   mult_multicycle_o,
  // CSR and LSU
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_err_i,
  input  logic                   lsu_ready_ex_i,
  // Register writes from ID
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,
  // To IF
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,
  // Forward port to ID and regfile
  output logic                   regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o,
  // LSU write port to WB
  output logic                   regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]    regfile_wdata_wb_o,
  // Handshake
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  // Branch outcome straight from the compare
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////
  // ALU
  ////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ////////////////////
  // Multiplier
  ////////////////////

  // Stage ready releases the high word
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////
  // Write-back control
  ////////////////////

  ex_wb_ctrl u_wb_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_err_i              (lsu_err_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- hdl/ex_wb_ctrl.sv
// Execute stage write-back control
// Forward port select, EX/WB register on the LSU port and stall logic

`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_wb_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  // Unit enables
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic                  lsu_en_i,
  // Result sources
  input  logic [`EX_XLEN-1:0]   alu_result_i,
  input  logic [`EX_XLEN-1:0]   mult_result_i,
  input  logic [`EX_XLEN-1:0]   csr_rdata_i,
  input  logic [`EX_XLEN-1:0]   lsu_rdata_i,
  // Write requests from ID
  input  logic                  regfile_alu_we_i,
  input  logic                  regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  // Stall sources
  input  logic                  lsu_err_i,
  input  logic                  mult_ready_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  wb_ready_i,
  input  logic                  branch_in_ex_i,
  // Forward port
  output logic                  regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]   regfile_alu_wdata_fw_o,
  // LSU write port
  output logic                  regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]   regfile_wdata_wb_o,
  // Handshake
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic units_ready;
  logic any_en;
  logic wb_we_d;

  ////////////////////
  // Forward port
  ////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR over multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ////////////////////
  // Stall control
  ////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches finish here, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = any_en & units_ready;

  ////////////////////
  // EX/WB register
  ////////////////////

  // A faulting load does not write
  assign wb_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= wb_we_d;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, flush the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && wb_we_d) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  // Load data arrives in WB, not registered here
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_ctrl.sv
hdl/ex_stage.sv
tb/ex_stage_checker.sv
tb/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f list.f \
  --top-module ex_stage_tb -Mdir obj_dir -o sim_ex_stage \
  && { ./obj_dir/sim_ex_stage +verilator+error+limit+100000 > sim.log 2>&1; cat sim.log; } \
  && ! grep -q "RESULT: FAIL" sim.log \
  && grep -q "RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb/ex_stage_checker.sv
// Execute stage checker
// Reference ALU and multiplier models with assertions bound into ex_stage

`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ex_pkg::alu_op_e        alu_operator_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_c_i,
  input  logic                   alu_en_i,
  input  ex_pkg::mul_op_e        mult_operator_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_b_i,
  input  logic                   mult_en_i,
  input  logic                   mult_multicycle_o,
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_err_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,
  input  logic [`EX_XLEN-1:0]    jump_target_o,
  input  logic                   branch_decision_o,
  input  logic                   regfile_alu_we_fw_o,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o,
  input  logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o,
  input  logic                   regfile_we_wb_o,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o,
  input  logic [`EX_XLEN-1:0]    regfile_wdata_wb_o,
  input  logic                   ex_ready_o,
  input  logic                   ex_valid_o
);

  int err_count = 0;

  // Branch and set-less-than compare bit
  function automatic logic ref_cmp(input ex_pkg::alu_op_e op,
                                   input logic [`EX_XLEN-1:0] a,
                                   input logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::EQ:                return a == b;
      ex_pkg::NE:                return a != b;
      ex_pkg::LT, ex_pkg::SLT:   return $signed(a) < $signed(b);
      ex_pkg::GE:                return $signed(a) >= $signed(b);
      ex_pkg::LTU, ex_pkg::SLTU: return a < b;
      ex_pkg::GEU:               return a >= b;
      default:                   return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] ref_alu(input ex_pkg::alu_op_e op,
                                                  input logic [`EX_XLEN-1:0] a,
                                                  input logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::ADD: return a + b;
      ex_pkg::SUB: return a - b;
      ex_pkg::AND: return a & b;
      ex_pkg::OR:  return a | b;
      ex_pkg::XOR: return a ^ b;
      ex_pkg::SLL: return a << b[4:0];
      ex_pkg::SRL: return a >> b[4:0];
      ex_pkg::SRA: return $unsigned($signed(a) >>> b[4:0]);
      default:     return {{(`EX_XLEN-1){1'b0}}, ref_cmp(op, a, b)};
    endcase
  endfunction

  // Low or high word of the 64-bit product of the extended operands
  function automatic logic [`EX_XLEN-1:0] ref_mul(input ex_pkg::mul_op_e op,
                                                  input logic [`EX_XLEN-1:0] a,
                                                  input logic [`EX_XLEN-1:0] b);
    logic [2*`EX_XLEN-1:0] ax;
    logic [2*`EX_XLEN-1:0] bx;
    logic [2*`EX_XLEN-1:0] p;
    ax = (op == ex_pkg::MULH || op == ex_pkg::MULHSU) ?
         {{`EX_XLEN{a[`EX_XLEN-1]}}, a} : {{`EX_XLEN{1'b0}}, a};
    bx = (op == ex_pkg::MULH) ? {{`EX_XLEN{b[`EX_XLEN-1]}}, b} : {{`EX_XLEN{1'b0}}, b};
    p  = ax * bx;
    return (op == ex_pkg::MUL) ? p[`EX_XLEN-1:0] : p[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  ////////////////////
  // Expected state
  ////////////////////

  logic                   done_q;
  logic                   after_rst_q;
  logic                   exp_we_wb_q;
  logic [`EX_RADDR_W-1:0] exp_waddr_q;
  logic                   first_high;
  logic                   exp_mready;
  logic                   exp_ready;
  logic                   exp_valid;
  logic                   fwd_known;
  logic [`EX_XLEN-1:0]    exp_fwd;

  // First cycle of a high multiply holds the stage
  assign first_high = mult_en_i & (mult_operator_i != ex_pkg::MUL) & ~done_q;
  assign exp_mready = ~first_high;
  assign exp_ready  = (exp_mready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign exp_valid  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) &
                      exp_mready & lsu_ready_ex_i & wb_ready_i;
  // Low word during the first high cycle is not defined
  assign fwd_known  = ~(first_high & ~csr_access_i);

  always_comb begin
    if (csr_access_i) begin
      exp_fwd = csr_rdata_i;
    end else if (mult_en_i) begin
      exp_fwd = ref_mul(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
    end else if (alu_en_i) begin
      exp_fwd = ref_alu(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    end else begin
      exp_fwd = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q      <= 1'b0;
      after_rst_q <= 1'b1;
      exp_we_wb_q <= 1'b0;
    end else begin
      after_rst_q <= 1'b0;
      if (!done_q) begin
        done_q <= first_high;
      end else if (exp_ready) begin
        done_q <= 1'b0;
      end
      if (exp_valid) begin
        exp_we_wb_q <= regfile_we_i & ~lsu_err_i;
      end else if (wb_ready_i) begin
        exp_we_wb_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exp_valid && regfile_we_i && !lsu_err_i) begin
      exp_waddr_q <= regfile_waddr_i;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_fwd_data: assert property (@(posedge clk) disable iff (!rst_n)
      fwd_known |-> regfile_alu_wdata_fw_o == exp_fwd)
    else begin
      $error("FAILED fwd_data: expected %h, actual %h",
             $sampled(exp_fwd), $sampled(regfile_alu_wdata_fw_o));
      err_count = err_count + 1;
    end

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
      branch_decision_o == ref_cmp(alu_operator_i, alu_operand_a_i, alu_operand_b_i))
    else begin
      $error("FAILED branch_decision: expected %b, actual %b",
             ref_cmp(alu_operator_i, alu_operand_a_i, alu_operand_b_i), branch_decision_o);
      err_count = err_count + 1;
    end

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
      jump_target_o == alu_operand_c_i)
    else begin
      $error("FAILED jump_target: expected %h, actual %h", alu_operand_c_i, jump_target_o);
      err_count = err_count + 1;
    end

  // Write enable and address side by side
  a_fwd_port: assert property (@(posedge clk) disable iff (!rst_n)
      {regfile_alu_we_fw_o, regfile_alu_waddr_fw_o} == {regfile_alu_we_i, regfile_alu_waddr_i})
    else begin
      $error("FAILED fwd_we_waddr: expected %h, actual %h",
             {regfile_alu_we_i, regfile_alu_waddr_i},
             {regfile_alu_we_fw_o, regfile_alu_waddr_fw_o});
      err_count = err_count + 1;
    end

  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ex_ready_o == exp_ready)
    else begin
      $error("FAILED ex_ready: expected %b, actual %b",
             $sampled(exp_ready), $sampled(ex_ready_o));
      err_count = err_count + 1;
    end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o == exp_valid)
    else begin
      $error("FAILED ex_valid: expected %b, actual %b",
             $sampled(exp_valid), $sampled(ex_valid_o));
      err_count = err_count + 1;
    end

  a_multicycle: assert property (@(posedge clk) disable iff (!rst_n)
      mult_multicycle_o == done_q)
    else begin
      $error("FAILED mult_multicycle: expected %b, actual %b",
             $sampled(done_q), $sampled(mult_multicycle_o));
      err_count = err_count + 1;
    end

  a_we_wb: assert property (@(posedge clk) disable iff (!rst_n)
      regfile_we_wb_o == exp_we_wb_q)
    else begin
      $error("FAILED we_wb: expected %b, actual %b",
             $sampled(exp_we_wb_q), $sampled(regfile_we_wb_o));
      err_count = err_count + 1;
    end

  a_waddr_wb: assert property (@(posedge clk) disable iff (!rst_n)
      exp_we_wb_q |-> regfile_waddr_wb_o == exp_waddr_q)
    else begin
      $error("FAILED waddr_wb: expected %h, actual %h",
             $sampled(exp_waddr_q), $sampled(regfile_waddr_wb_o));
      err_count = err_count + 1;
    end

  a_wdata_wb: assert property (@(posedge clk) disable iff (!rst_n)
      regfile_wdata_wb_o == lsu_rdata_i)
    else begin
      $error("FAILED wdata_wb: expected %h, actual %h", lsu_rdata_i, regfile_wdata_wb_o);
      err_count = err_count + 1;
    end

  // Quiet outputs in reset and on the first edge out of it
  a_reset: assert property (@(posedge clk)
      (!rst_n || after_rst_q) |-> !regfile_we_wb_o && !mult_multicycle_o && !ex_valid_o)
    else begin
      $error("FAILED reset_state: expected 000, actual %b%b%b",
             $sampled(regfile_we_wb_o), $sampled(mult_multicycle_o), $sampled(ex_valid_o));
      err_count = err_count + 1;
    end

endmodule

`default_nettype wire

//--- tb/ex_stage_tb.sv
// Execute stage testbench
// Random instruction stream with back-pressure, checked by the bound checker

`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage_tb;

  localparam int NUM_INSTR    = 400;
  localparam int RESET_CYCLES = 4;
  // Up to 3 cycles per instruction, plus reset and margin
  localparam int MAX_CYCLES   = NUM_INSTR * 3 + 800;

  localparam ex_pkg::alu_op_e ALU_OPS [16] = '{
    ex_pkg::ADD, ex_pkg::SUB, ex_pkg::AND, ex_pkg::OR,
    ex_pkg::XOR, ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA,
    ex_pkg::SLT, ex_pkg::SLTU, ex_pkg::EQ, ex_pkg::NE,
    ex_pkg::LT, ex_pkg::GE, ex_pkg::LTU, ex_pkg::GEU
  };

  logic                   clk;
  logic                   rst_n;
  ex_pkg::alu_op_e        alu_operator_i;
  logic [`EX_XLEN-1:0]    alu_operand_a_i;
  logic [`EX_XLEN-1:0]    alu_operand_b_i;
  logic [`EX_XLEN-1:0]    alu_operand_c_i;
  logic                   alu_en_i;
  ex_pkg::mul_op_e        mult_operator_i;
  logic [`EX_XLEN-1:0]    mult_operand_a_i;
  logic [`EX_XLEN-1:0]    mult_operand_b_i;
  logic                   mult_en_i;
  logic                   mult_multicycle_o;
  logic                   csr_access_i;
  logic [`EX_XLEN-1:0]    csr_rdata_i;
  logic                   lsu_en_i;
  logic [`EX_XLEN-1:0]    lsu_rdata_i;
  logic                   lsu_err_i;
  logic                   lsu_ready_ex_i;
  logic                   regfile_alu_we_i;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i;
  logic                   regfile_we_i;
  logic [`EX_RADDR_W-1:0] regfile_waddr_i;
  logic                   branch_in_ex_i;
  logic                   wb_ready_i;
  logic [`EX_XLEN-1:0]    jump_target_o;
  logic                   branch_decision_o;
  logic                   regfile_alu_we_fw_o;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o;
  logic                   regfile_we_wb_o;
  logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o;
  logic [`EX_XLEN-1:0]    regfile_wdata_wb_o;
  logic                   ex_ready_o;
  logic                   ex_valid_o;

  logic [31:0] lfsr;
  int          cycle_count;
  int          timeout_count;
  int          instr_count;

  ex_stage dut (.*);

  bind ex_stage ex_stage_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Random source
  ////////////////////

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic init_inputs();
    alu_operator_i      = ex_pkg::ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = ex_pkg::MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_err_i           = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    branch_in_ex_i      = 1'b0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic load_instr();
    logic [31:0] r;
    draw_bits(4, r);
    alu_operator_i = ALU_OPS[r[3:0]];
    draw_bits(32, r);
    alu_operand_a_i = r;
    draw_bits(3, r);
    // Equal operands now and then so EQ/GE paths are hit
    if (r[2:0] == 3'd0) begin
      alu_operand_b_i = alu_operand_a_i;
    end else begin
      draw_bits(32, r);
      alu_operand_b_i = r;
    end
    draw_bits(32, r);
    alu_operand_c_i = r;
    draw_bits(1, r);
    alu_en_i = r[0];
    draw_bits(1, r);
    mult_en_i = r[0];
    draw_bits(2, r);
    mult_operator_i = ex_pkg::mul_op_e'(r[1:0]);
    draw_bits(32, r);
    mult_operand_a_i = r;
    draw_bits(32, r);
    mult_operand_b_i = r;
    draw_bits(2, r);
    csr_access_i = (r[1:0] == 2'd0);
    draw_bits(32, r);
    csr_rdata_i = r;
    draw_bits(1, r);
    lsu_en_i = r[0];
    draw_bits(32, r);
    lsu_rdata_i = r;
    draw_bits(3, r);
    lsu_err_i = (r[2:0] == 3'd0);
    draw_bits(7, r);
    regfile_alu_we_i    = r[6];
    regfile_alu_waddr_i = r[5:0];
    draw_bits(7, r);
    regfile_we_i    = r[6];
    regfile_waddr_i = r[5:0];
    // Branches never carry a multiply
    draw_bits(2, r);
    branch_in_ex_i = (r[1:0] == 2'd0) && !mult_en_i;
  endtask

  // Low rate stalls from LSU and WB
  task automatic drive_pressure();
    logic [31:0] r;
    draw_bits(3, r);
    wb_ready_i = (r[2:0] != 3'd0);
    draw_bits(3, r);
    lsu_ready_ex_i = (r[2:0] != 3'd0);
  endtask

  // Hold the instruction until the stage takes it
  task automatic run_until_accepted();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      drive_pressure();
      @(negedge clk);
      taken = ex_ready_o;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_run();
    int total;
    total = dut.u_checker.err_count + timeout_count;
    $display("Run ended after %0d cycles: %0d instructions, %0d assertion errors, %0d timeouts",
             cycle_count, instr_count, dut.u_checker.err_count, timeout_count);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    lfsr          = 32'hd621;
    instr_count   = 0;
    timeout_count = 0;
    init_inputs();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // First edge out of reset sees no request
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_INSTR; n++) begin
      load_instr();
      run_until_accepted();
      instr_count++;
    end
    // Drain the EX/WB slot
    init_inputs();
    repeat (3) @(posedge clk);
    #1;
    finish_run();
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    timeout_count++;
    finish_run();
  end

endmodule

`default_nettype wire
